// ==== Makefile ====
# verilator build and run of the input buffer testbench

BIN  := obj_dir/Vtb_input_buffer
SRCS := compile.f noc_buf_pkg.sv vc_ptr_track.sv flit_ram.sv flit_out_sel.sv \
        input_buffer.sv tb_flit_model.svh tb_input_buffer.sv

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SRCS)
	verilator --binary --assert -f compile.f --top-module tb_input_buffer -o Vtb_input_buffer

# pass only when the log holds the pass line
run: $(BIN)
	./$(BIN) | tee sim.log
	grep -qF '** PASS **' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+.
noc_buf_pkg.sv
vc_ptr_track.sv
flit_ram.sv
flit_out_sel.sv
input_buffer.sv
tb_input_buffer.sv

// ==== flit_out_sel.sv ====
`default_nettype none

module flit_out_sel #(
    parameter bit ssa_en = 1'b1
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire logic                   rd_en,
    input  wire noc_buf_pkg::flit_word_t wr_data,
    input  wire noc_buf_pkg::flit_word_t ram_rd_data,
    output noc_buf_pkg::flit_word_t     flit_out
);

    import noc_buf_pkg::*;

    if (ssa_en) begin : g_bypass
        // incoming flit, one cycle late, for the ssa path
        flit_word_t bypass_q;
        // remembers whether last cycle was a normal read
        logic       rd_en_q;

        always_ff @(posedge clk) begin
            bypass_q <= wr_data;
        end

        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                rd_en_q <= 1'b0;
            end else begin
                rd_en_q <= rd_en;
            end
        end

        // ram data after a normal read, bypass word otherwise
        // bypass word only means something after an ssa pop
        assign flit_out = rd_en_q ? ram_rd_data : bypass_q;
    end else begin : g_no_bypass
        // no speculation, output follows the last ram read
        assign flit_out = ram_rd_data;
    end

endmodule

`default_nettype wire

// ==== flit_ram.sv ====
`default_nettype none

module flit_ram (
    input  wire logic                   clk,
    input  wire logic                   ram_wr,
    input  wire noc_buf_pkg::ram_addr_t  ram_wr_addr,
    input  wire noc_buf_pkg::flit_word_t wr_data,
    input  wire logic                   ram_rd,
    input  wire noc_buf_pkg::ram_addr_t  ram_rd_addr,
    output noc_buf_pkg::flit_word_t     ram_rd_data
);

    import noc_buf_pkg::*;

    // all vc slices share this one array
    // slice k sits at addresses k*vc_depth .. k*vc_depth+vc_depth-1
    flit_word_t mem [ram_words];

    // write port
    always_ff @(posedge clk) begin
        if (ram_wr) begin
            mem[ram_wr_addr] <= wr_data;
        end
    end

    // registered read port
    // holds its last word while no read is issued
    // read-first on an address clash, which happens when a full slice
    // is read and written in the same cycle, the head must come out
    always_ff @(posedge clk) begin
        if (ram_rd) begin
            ram_rd_data <= mem[ram_rd_addr];
        end
    end

endmodule

`default_nettype wire

// ==== input_buffer.sv ====
`default_nettype none

module input_buffer #(
    parameter bit ssa_en = 1'b1
) (
    input  wire logic                   clk,
    input  wire logic                   reset,
    input  wire noc_buf_pkg::flit_type_t flit_type_in,
    input  wire noc_buf_pkg::payload_t   payload_in,
    input  wire logic                   wr_en,
    input  wire noc_buf_pkg::vc_mask_t   vc_num_wr,
    input  wire logic                   rd_en,
    input  wire noc_buf_pkg::vc_mask_t   vc_num_rd,
    input  wire noc_buf_pkg::vc_mask_t   ssa_rd,
    output noc_buf_pkg::flit_type_t     flit_type_out,
    output noc_buf_pkg::payload_t       payload_out,
    output noc_buf_pkg::vc_mask_t       vc_not_empty
);

    import noc_buf_pkg::*;

    // stage 1 to stage 2
    logic      ram_wr;
    ram_addr_t ram_wr_addr;
    logic      ram_rd;
    ram_addr_t ram_rd_addr;

    // stage 2 to stage 3
    flit_word_t ram_rd_data;

    flit_word_t flit_word_in;
    flit_word_t flit_word_out;

    // type rides above the payload in the ram word
    assign flit_word_in = {flit_type_in, payload_in};

    assign flit_type_out = flit_word_out[payload_width +: flit_type_width];
    assign payload_out   = flit_word_out[payload_width-1:0];

    // pointers, counts, addresses
    vc_ptr_track u_vc_ptr_track (
        .clk          (clk),
        .reset        (reset),
        .wr_en        (wr_en),
        .vc_num_wr    (vc_num_wr),
        .rd_en        (rd_en),
        .vc_num_rd    (vc_num_rd),
        .ssa_rd       (ssa_rd),
        .ram_wr       (ram_wr),
        .ram_wr_addr  (ram_wr_addr),
        .ram_rd       (ram_rd),
        .ram_rd_addr  (ram_rd_addr),
        .vc_not_empty (vc_not_empty)
    );

    // shared slice storage
    flit_ram u_flit_ram (
        .clk         (clk),
        .ram_wr      (ram_wr),
        .ram_wr_addr (ram_wr_addr),
        .wr_data     (flit_word_in),
        .ram_rd      (ram_rd),
        .ram_rd_addr (ram_rd_addr),
        .ram_rd_data (ram_rd_data)
    );

    // bypass and output mux
    flit_out_sel #(
        .ssa_en (ssa_en)
    ) u_flit_out_sel (
        .clk         (clk),
        .reset       (reset),
        .rd_en       (rd_en),
        .wr_data     (flit_word_in),
        .ram_rd_data (ram_rd_data),
        .flit_out    (flit_word_out)
    );

endmodule

`default_nettype wire

// ==== noc_buf_pkg.sv ====
`default_nettype none

package noc_buf_pkg;

    // port geometry
    localparam int num_vc        = 4;
    // flits per vc slice, power of two so pointers wrap on their own
    localparam int vc_depth      = 4;
    localparam int payload_width = 32;
    // header and tail marker bits
    localparam int flit_type_width = 2;

    // derived widths
    localparam int vc_idx_width = $clog2(num_vc);
    localparam int ptr_width    = $clog2(vc_depth);
    // count runs 0..vc_depth, one bit wider than a pointer
    localparam int depth_width  = $clog2(vc_depth + 1);
    // all slices laid out back to back in one ram
    localparam int ram_words    = num_vc * vc_depth;

    typedef logic [num_vc-1:0]                        vc_mask_t;
    typedef logic [vc_idx_width-1:0]                  vc_idx_t;
    typedef logic [ptr_width-1:0]                     ptr_t;
    typedef logic [depth_width-1:0]                   depth_t;
    // vc number on top, slice pointer below
    typedef logic [vc_idx_width+ptr_width-1:0]        ram_addr_t;
    typedef logic [flit_type_width-1:0]               flit_type_t;
    typedef logic [payload_width-1:0]                 payload_t;
    // ram word, type above payload
    typedef logic [flit_type_width+payload_width-1:0] flit_word_t;

    // occupancy of a full slice
    localparam depth_t depth_full = depth_t'(vc_depth);

endpackage

`default_nettype wire

// ==== tb_flit_model.svh ====
`ifndef TB_FLIT_MODEL_SVH
`define TB_FLIT_MODEL_SVH

// expected contents of each vc slice, head at index 0
flit_word_t model_q [num_vc][$];

// slice has no room left
function automatic bit model_full(input int v);
    return model_q[v].size() >= vc_depth;
endfunction

// lowest vc still holding flits, -1 when all are empty
function automatic int model_first_busy();
    for (int v = 0; v < num_vc; v++) begin
        if (model_q[v].size() != 0) begin
            return v;
        end
    end
    return -1;
endfunction

// folds one cycle of requests into the queues
// returns the flit due on the outputs during the next cycle
function automatic flit_word_t model_step(
    input  logic       wr,
    input  vc_mask_t   wvc,
    input  flit_word_t wdata,
    input  logic       rd,
    input  vc_mask_t   rvc,
    input  vc_mask_t   ssa,
    output logic       popped,
    output vc_mask_t   not_empty
);
    vc_mask_t   pops;
    flit_word_t head;
    // normal read wins over the ssa mask
    pops   = rd ? rvc : ssa;
    popped = 1'b0;
    head   = '0;
    for (int v = 0; v < num_vc; v++) begin
        // push first, so an ssa pop of an empty vc gets its own flit
        if (wr && wvc[v]) begin
            model_q[v].push_back(wdata);
        end
        if (pops[v] && (model_q[v].size() != 0)) begin
            head   = model_q[v].pop_front();
            popped = 1'b1;
        end
    end
    for (int v = 0; v < num_vc; v++) begin
        not_empty[v] = (model_q[v].size() != 0);
    end
    return head;
endfunction

`endif

// ==== tb_input_buffer.sv ====
`default_nettype none

module tb_input_buffer;

    import noc_buf_pkg::*;

    `include "tb_flit_model.svh"

    // test lengths in cycles, the run limit is twice their sum
    localparam int reset_cycles = 16;
    localparam int len_reset    = 4;
    localparam int len_fill     = num_vc * (2 * vc_depth + 1) + 1;
    localparam int len_wrap     = 3 * vc_depth * num_vc + num_vc + 2;
    localparam int len_cross    = 5 * vc_depth + 2;
    localparam int len_ssa      = 3 * num_vc + 4;
    localparam int len_rand     = 400 + num_vc * vc_depth + 2;
    localparam int cycle_limit  = 2 * (reset_cycles + len_reset + len_fill + len_wrap
                                       + len_cross + len_ssa + len_rand);

    logic       clk;
    logic       reset;
    flit_type_t flit_type_in;
    payload_t   payload_in;
    logic       wr_en;
    vc_mask_t   vc_num_wr;
    logic       rd_en;
    vc_mask_t   vc_num_rd;
    vc_mask_t   ssa_rd;
    flit_type_t flit_type_out;
    payload_t   payload_out;
    vc_mask_t   vc_not_empty;

    // what the outputs should show this cycle, from last cycle's requests
    flit_word_t  exp_flit  = '0;
    logic        exp_valid = 1'b0;
    vc_mask_t    exp_ne    = '0;
    logic        checking  = 1'b0;
    int          checks    = 0;
    int          errors    = 0;
    int          cycles    = 0;
    int unsigned first_rand;

    input_buffer #(
        .ssa_en (1'b1)
    ) uut (
        .clk           (clk),
        .reset         (reset),
        .flit_type_in  (flit_type_in),
        .payload_in    (payload_in),
        .wr_en         (wr_en),
        .vc_num_wr     (vc_num_wr),
        .rd_en         (rd_en),
        .vc_num_rd     (vc_num_rd),
        .ssa_rd        (ssa_rd),
        .flit_type_out (flit_type_out),
        .payload_out   (payload_out),
        .vc_not_empty  (vc_not_empty)
    );

    always #20 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("run stopped after %0d cycles, tests did not finish", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // compare at the falling edge, then fold in this cycle's requests
    always @(negedge clk) begin
        if (checking) begin
            if (exp_valid) begin
                checks++;
                assert (flit_type_out == exp_flit[payload_width +: flit_type_width]) else begin
                    errors++;
                    $display("ERR flit_type_out expected %h got %h",
                             exp_flit[payload_width +: flit_type_width], flit_type_out);
                end
                checks++;
                assert (payload_out == exp_flit[payload_width-1:0]) else begin
                    errors++;
                    $display("ERR payload_out expected %h got %h",
                             exp_flit[payload_width-1:0], payload_out);
                end
            end
            checks++;
            assert (vc_not_empty == exp_ne) else begin
                errors++;
                $display("ERR vc_not_empty expected %h got %h", exp_ne, vc_not_empty);
            end
            exp_flit = model_step(wr_en, vc_num_wr, {flit_type_in, payload_in},
                                  rd_en, vc_num_rd, ssa_rd, exp_valid, exp_ne);
        end
    end

    function automatic vc_mask_t vc_onehot(input int v);
        return vc_mask_t'(1) << v;
    endfunction

    // requests for the cycle that starts at this edge, random flit data
    task automatic set_inputs(input logic wr, input int wv, input logic rd,
                              input int rv, input logic ssa, input int sv);
        flit_type_in <= flit_type_t'($urandom_range(3, 0));
        payload_in   <= $urandom();
        wr_en        <= wr;
        vc_num_wr    <= wr ? vc_onehot(wv) : '0;
        rd_en        <= rd;
        vc_num_rd    <= rd ? vc_onehot(rv) : '0;
        ssa_rd       <= ssa ? vc_onehot(sv) : '0;
    endtask

    task automatic drive_cycle(input logic wr, input int wv, input logic rd,
                               input int rv, input logic ssa, input int sv);
        @(posedge clk);
        set_inputs(wr, wv, rd, rv, ssa, sv);
    endtask

    task automatic drive_idle();
        drive_cycle(1'b0, 0, 1'b0, 0, 1'b0, 0);
    endtask

    // pops whatever the model still holds, one flit per cycle
    // decisions come after the edge, once the model saw last cycle
    task automatic drain_all();
        int busy;
        @(posedge clk);
        busy = model_first_busy();
        while (busy >= 0) begin
            set_inputs(1'b0, 0, 1'b1, busy, 1'b0, 0);
            @(posedge clk);
            busy = model_first_busy();
        end
        set_inputs(1'b0, 0, 1'b0, 0, 1'b0, 0);
    endtask

    // one more edge so the last output has been compared
    task automatic report_test(input string name, input int start_err);
        @(posedge clk);
        $display("test %s done, %0d errors", name, errors - start_err);
    endtask

    task automatic test_reset();
        int start_err;
        start_err = errors;
        // flags checked on every idle cycle against an empty model
        repeat (len_reset - 1) drive_idle();
        report_test("reset state", start_err);
    endtask

    task automatic test_fill_drain();
        int start_err;
        start_err = errors;
        for (int v = 0; v < num_vc; v++) begin
            repeat (vc_depth) drive_cycle(1'b1, v, 1'b0, 0, 1'b0, 0);
            repeat (vc_depth) drive_cycle(1'b0, 0, 1'b1, v, 1'b0, 0);
            drive_idle();
        end
        report_test("fill and drain", start_err);
    endtask

    task automatic test_wrap();
        int start_err;
        start_err = errors;
        // write vc i, read vc i+1, written three cycles before
        // twelve flits per vc take each pointer round three times
        for (int i = 0; i < 3 * vc_depth * num_vc; i++) begin
            drive_cycle(1'b1, i % num_vc, (i >= num_vc - 1), (i + 1) % num_vc, 1'b0, 0);
        end
        drain_all();
        report_test("pointer wrap", start_err);
    endtask

    task automatic test_cross();
        int start_err;
        start_err = errors;
        repeat (vc_depth) drive_cycle(1'b1, 0, 1'b0, 0, 1'b0, 0);
        // back to back reads of one vc while the next one fills
        for (int v = 0; v < num_vc - 1; v++) begin
            repeat (vc_depth) drive_cycle(1'b1, v + 1, 1'b1, v, 1'b0, 0);
        end
        drain_all();
        report_test("read and write across vcs", start_err);
    endtask

    task automatic test_ssa();
        int start_err;
        start_err = errors;
        // lone pops on empty vcs
        for (int v = 0; v < num_vc; v++) begin
            drive_cycle(1'b1, v, 1'b0, 0, 1'b1, v);
            drive_idle();
        end
        // vc0 keeps its flit while the others bypass back to back
        drive_cycle(1'b1, 0, 1'b0, 0, 1'b0, 0);
        for (int v = 1; v < num_vc; v++) begin
            drive_cycle(1'b1, v, 1'b0, 0, 1'b1, v);
        end
        drain_all();
        report_test("ssa bypass", start_err);
    endtask

    task automatic test_random();
        int   start_err;
        int   wv;
        int   rv;
        logic wr;
        logic rd;
        logic ssa;
        start_err = errors;
        for (int i = 0; i < 400; i++) begin
            @(posedge clk);
            rv  = int'($urandom_range(num_vc - 1, 0));
            wv  = int'($urandom_range(num_vc - 1, 0));
            rd  = ($urandom_range(1, 0) == 1) && (model_q[rv].size() != 0);
            // a full vc only takes a flit while its head leaves
            wr  = ($urandom_range(3, 0) != 0) && (!model_full(wv) || (rd && (rv == wv)));
            // speculative pop only of an empty vc written this cycle
            ssa = !rd && wr && (model_q[wv].size() == 0) && ($urandom_range(2, 0) == 0);
            set_inputs(wr, wv, rd, rv, ssa, wv);
        end
        drain_all();
        report_test("random traffic", start_err);
    endtask

    initial begin
        first_rand = $urandom(32'hd9abdc05);
        clk = 1'b0;
        reset        <= 1'b1;
        flit_type_in <= '0;
        payload_in   <= '0;
        wr_en        <= 1'b0;
        vc_num_wr    <= '0;
        rd_en        <= 1'b0;
        vc_num_rd    <= '0;
        ssa_rd       <= '0;
        repeat (reset_cycles) @(posedge clk);
        reset    <= 1'b0;
        checking = 1'b1;

        test_reset();
        test_fill_drain();
        test_wrap();
        test_cross();
        test_ssa();
        test_random();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vc_ptr_track.sv ====
`default_nettype none

module vc_ptr_track (
    input  wire logic                 clk,
    input  wire logic                 reset,
    input  wire logic                 wr_en,
    input  wire noc_buf_pkg::vc_mask_t vc_num_wr,
    input  wire logic                 rd_en,
    input  wire noc_buf_pkg::vc_mask_t vc_num_rd,
    input  wire noc_buf_pkg::vc_mask_t ssa_rd,
    output logic                      ram_wr,
    output noc_buf_pkg::ram_addr_t    ram_wr_addr,
    output logic                      ram_rd,
    output noc_buf_pkg::ram_addr_t    ram_rd_addr,
    output noc_buf_pkg::vc_mask_t     vc_not_empty
);

    import noc_buf_pkg::*;

    // per-vc state, packed so it can be handed to the address function
    ptr_t   [num_vc-1:0] wr_ptr;
    ptr_t   [num_vc-1:0] rd_ptr;
    depth_t [num_vc-1:0] depth;

    vc_mask_t wr_mask;
    vc_mask_t pop_mask;

    // one-hot vc select plus that vc's pointer gives the ram address
    // or-reduction keeps it a plain and-or mux for one-hot selects
    function automatic ram_addr_t vc_addr(input vc_mask_t sel,
                                          input ptr_t [num_vc-1:0] ptrs);
        vc_idx_t idx;
        ptr_t    ptr;
        idx = '0;
        ptr = '0;
        for (int v = 0; v < num_vc; v++) begin
            if (sel[v]) begin
                idx = idx | vc_idx_t'(v);
                ptr = ptr | ptrs[v];
            end
        end
        return {idx, ptr};
    endfunction

    // write only counts when enabled
    assign wr_mask  = wr_en ? vc_num_wr : '0;
    // normal read has priority, ssa mask pops otherwise
    assign pop_mask = rd_en ? vc_num_rd : ssa_rd;

    // ram side strobes, same cycle as the request
    assign ram_wr      = wr_en;
    assign ram_wr_addr = vc_addr(vc_num_wr, wr_ptr);
    // ssa pops never touch the ram, the bypass register serves them
    assign ram_rd      = rd_en;
    assign ram_rd_addr = vc_addr(vc_num_rd, rd_ptr);

    always_comb begin
        for (int v = 0; v < num_vc; v++) begin
            vc_not_empty[v] = (depth[v] != '0);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            depth  <= '0;
        end else begin
            for (int v = 0; v < num_vc; v++) begin
                // pointers wrap inside the slice by overflow
                if (wr_mask[v]) begin
                    wr_ptr[v] <= wr_ptr[v] + ptr_t'(1);
                end
                if (pop_mask[v]) begin
                    rd_ptr[v] <= rd_ptr[v] + ptr_t'(1);
                end
                // write and pop together leave the count alone
                if (wr_mask[v] && !pop_mask[v]) begin
                    depth[v] <= depth[v] + depth_t'(1);
                end else if (!wr_mask[v] && pop_mask[v]) begin
                    depth[v] <= depth[v] - depth_t'(1);
                end
            end
        end
    end

    // sender discipline, there is no back-pressure to protect the slices
    for (genvar v = 0; v < num_vc; v++) begin : g_vc_chk
        // overflow, a full slice only takes a flit when its head leaves
        a_no_overflow: assert property (@(posedge clk) disable iff (reset)
            (wr_mask[v] && !pop_mask[v]) |-> (depth[v] != depth_full))
            else $error("write to full vc %0d", v);

        // underflow, only an ssa pop of a flit arriving this cycle is legal
        a_no_underflow: assert property (@(posedge clk) disable iff (reset)
            (pop_mask[v] && (depth[v] == '0)) |-> (!rd_en && wr_mask[v]))
            else $error("pop of empty vc %0d", v);
    end

    // an enable needs somewhere to go
    a_wr_sel: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (vc_num_wr != '0))
        else $error("wr_en without a write vc");

    a_rd_sel: assert property (@(posedge clk) disable iff (reset)
        rd_en |-> (vc_num_rd != '0))
        else $error("rd_en without a read vc");

endmodule

`default_nettype wire
